/* xt_bus_pkg.sv */
// Address map and read source encoding for the XT peripheral glue
// Shared by the I/O decoder, the EMS mapper and the read-data path
package xt_bus_pkg;

    // Bus widths
    localparam int bus_addr_w     = 20;
    localparam int bus_data_w     = 8;
    localparam int io_port_w      = 16;
    localparam int io_block_sel_w = 3;

    // 32-byte blocks in 000h-0FFh, one per external chip
    localparam logic [io_block_sel_w-1:0] blk_dma      = 3'd0;
    localparam logic [io_block_sel_w-1:0] blk_pic      = 3'd1;
    localparam logic [io_block_sel_w-1:0] blk_pit      = 3'd2;
    localparam logic [io_block_sel_w-1:0] blk_ppi      = 3'd3;
    localparam logic [io_block_sel_w-1:0] blk_dma_page = 3'd4;

    // Local registers
    localparam logic [io_port_w-1:0] ems_io_base   = 16'h0260;
    localparam logic [io_port_w-1:0] lpt_data_port = 16'h0378;
    localparam logic [io_port_w-1:0] lpt_ctl_port  = 16'h0379;

    // DSS-full flag position in the parallel status byte
    localparam int lpt_dss_full_bit = 6;

    typedef enum logic [2:0] {
        src_none,
        src_inta,
        src_pic,
        src_pit,
        src_ppi,
        src_ems,
        src_lpt_data,
        src_lpt_ctl
    } read_src_e;

endpackage

/* xt_ems_pkg.sv */
// EMS page mapper constants and window page bases
// Four slots of 16 KB, each holding a 7-bit page number
package xt_ems_pkg;

    localparam int ems_slots  = 4;
    localparam int ems_slot_w = 2;
    localparam int ems_map_w  = 7;

    // Write codes
    localparam logic [7:0] ems_disable_code = 8'hFF;
    localparam logic [7:0] ems_map_limit    = 8'h80;

    // Readback of a disabled slot
    localparam logic [7:0] ems_empty_read = 8'hFF;

    // Top four address bits of the 64 KB window
    typedef enum logic [3:0] {
        page_a000 = 4'b1010,
        page_c000 = 4'b1100,
        page_d000 = 4'b1101
    } ems_page_e;

endpackage

/* io_decoder.sv */
// I/O address decoder for the XT peripheral block
// Active-low selects for the external chips, active-high selects
// for the registers kept in this block; purely combinational
module io_decoder (
    input  logic [xt_bus_pkg::bus_addr_w-1:0] address_i,
    input  logic                              address_enable_n_i,
    input  logic                              io_read_n_i,
    input  logic                              io_write_n_i,
    output logic                              dma_cs_n_o,
    output logic                              pic_cs_n_o,
    output logic                              pit_cs_n_o,
    output logic                              ppi_cs_n_o,
    output logic                              dma_page_cs_n_o,
    output logic                              pic_sel_o,
    output logic                              pit_sel_o,
    output logic                              ppi_sel_o,
    output logic                              ems_sel_o,
    output logic                              lpt_data_sel_o,
    output logic                              lpt_ctl_sel_o,
    output logic                              io_cycle_o
);
    import xt_bus_pkg::*;

    logic                      io_cycle;
    logic                      low_io;
    logic [io_block_sel_w-1:0] block;
    logic [io_port_w-1:0]      port;

    assign io_cycle = ~address_enable_n_i & (~io_read_n_i | ~io_write_n_i);
    assign port     = address_i[io_port_w-1:0];
    assign block    = address_i[5 +: io_block_sel_w];

    // Motherboard chips live in 000h-0FFh
    assign low_io = io_cycle & (address_i[9:8] == 2'b00);

    assign dma_cs_n_o      = ~(low_io & (block == blk_dma));
    assign pic_cs_n_o      = ~(low_io & (block == blk_pic));
    assign pit_cs_n_o      = ~(low_io & (block == blk_pit));
    assign ppi_cs_n_o      = ~(low_io & (block == blk_ppi));
    assign dma_page_cs_n_o = ~(low_io & (block == blk_dma_page));

    assign pic_sel_o = ~pic_cs_n_o;
    assign pit_sel_o = ~pit_cs_n_o;
    assign ppi_sel_o = ~ppi_cs_n_o;

    // 260h-263h
    assign ems_sel_o      = io_cycle & (port[io_port_w-1:2] == ems_io_base[io_port_w-1:2]);
    assign lpt_data_sel_o = io_cycle & (port == lpt_data_port);
    assign lpt_ctl_sel_o  = io_cycle & (port == lpt_ctl_port);
    assign io_cycle_o     = io_cycle;

    ext_cs_onehot: assert final ($onehot0({~dma_cs_n_o, ~pic_cs_n_o, ~pit_cs_n_o,
                                           ~ppi_cs_n_o, ~dma_page_cs_n_o}))
        else $error("more than one external chip select active");

endmodule

/* ems_mapper.sv */
// EMS page mapper with four slot registers at 260h-263h
// Writes are registered and land one clock after the bus samples them;
// bank selects decode memory cycles inside the chosen 64 KB window
module ems_mapper (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [xt_bus_pkg::bus_addr_w-1:0]   address_i,
    input  logic [xt_bus_pkg::bus_data_w-1:0]   data_i,
    input  logic                                io_write_n_i,
    input  logic                                ems_sel_i,
    input  logic                                io_cycle_i,
    input  logic                                ems_enabled_i,
    input  logic [1:0]                          ems_window_i,
    output logic [xt_ems_pkg::ems_slots-1:0]    ems_bank_o,
    output logic [xt_ems_pkg::ems_slots-1:0][xt_ems_pkg::ems_map_w-1:0] ems_map_o,
    output logic [xt_bus_pkg::bus_data_w-1:0]   ems_read_data_o
);
    import xt_bus_pkg::*;
    import xt_ems_pkg::*;

    logic [ems_slots-1:0][ems_map_w-1:0] ems_map_q;
    logic [ems_slots-1:0]                ems_ena_q;

    logic                  ems_write_q;
    logic [ems_slot_w-1:0] wr_slot_q;
    logic [ems_map_w-1:0]  wr_page_q;
    logic                  wr_ena_q;

    logic                  disable_code;
    logic                  load_code;
    logic [ems_slot_w-1:0] rd_slot;
    ems_page_e             page_base;

    assign disable_code = (data_i == ems_disable_code);
    assign load_code    = (data_i < ems_map_limit);

    // Values 80h-FEh are ignored, so only the two real codes raise the write
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ems_write_q <= 1'b0;
        end else begin
            ems_write_q <= ems_sel_i & ems_enabled_i & ~io_write_n_i
                           & (disable_code | load_code);
        end
    end

    always_ff @(posedge clock) begin
        wr_slot_q <= address_i[ems_slot_w-1:0];
        wr_page_q <= disable_code ? {ems_map_w{1'b1}} : data_i[ems_map_w-1:0];
        wr_ena_q  <= ~disable_code;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ems_map_q <= '0;
            ems_ena_q <= '0;
        end else if (ems_write_q) begin
            ems_map_q[wr_slot_q] <= wr_page_q;
            ems_ena_q[wr_slot_q] <= wr_ena_q;
        end
    end

    assign ems_map_o = ems_map_q;

    assign rd_slot = address_i[ems_slot_w-1:0];
    assign ems_read_data_o = ems_ena_q[rd_slot]
                           ? {{(bus_data_w - ems_map_w){1'b0}}, ems_map_q[rd_slot]}
                           : ems_empty_read;

    // Selectors 2 and 3 share the D000 window
    always_comb begin
        case (ems_window_i)
            2'd0:    page_base = page_a000;
            2'd1:    page_base = page_c000;
            default: page_base = page_d000;
        endcase
    end

    for (genvar k = 0; k < ems_slots; k++) begin : g_bank
        assign ems_bank_o[k] = ~io_cycle_i & ems_ena_q[k]
            & (address_i[bus_addr_w-1 -: ($bits(ems_page_e) + ems_slot_w)]
               == {page_base, ems_slot_w'(k)});
    end

    slot_write_only: assert property (@(posedge clock) disable iff (reset)
        !ems_write_q |=> $stable(ems_map_q) && $stable(ems_ena_q))
        else $error("EMS slot changed without a registered write");

endmodule

/* timer_clock_gen.sv */
// Timer clock for the external 8253
// Toggles once per rising edge of the slow peripheral clock
module timer_clock_gen (
    input  logic clock,
    input  logic reset,
    input  logic peripheral_clock_i,
    output logic timer_clock_o
);
    logic sync_1;
    logic sync_2;
    logic prev_sync;
    logic rise;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync_1        <= 1'b0;
            sync_2        <= 1'b0;
            prev_sync     <= 1'b0;
            timer_clock_o <= 1'b0;
        end else begin
            sync_1    <= peripheral_clock_i;
            sync_2    <= sync_1;
            prev_sync <= sync_2;
            if (rise)
                timer_clock_o <= ~timer_clock_o;
        end
    end

    assign rise = sync_2 & ~prev_sync;

endmodule

/* bus_readback.sv */
// Read-data path back to the CPU bus
// Holds the parallel data latch and registers the highest-priority
// source together with the chipset-drives-bus flag
module bus_readback (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              io_read_n_i,
    input  logic                              io_write_n_i,
    input  logic                              memory_read_n_i,
    input  logic                              interrupt_acknowledge_n_i,
    input  logic [xt_bus_pkg::bus_data_w-1:0] data_i,
    input  logic                              pic_sel_i,
    input  logic                              pit_sel_i,
    input  logic                              ppi_sel_i,
    input  logic                              ems_sel_i,
    input  logic                              lpt_data_sel_i,
    input  logic                              lpt_ctl_sel_i,
    input  logic [xt_bus_pkg::bus_data_w-1:0] pic_data_i,
    input  logic [xt_bus_pkg::bus_data_w-1:0] pit_data_i,
    input  logic [xt_bus_pkg::bus_data_w-1:0] ppi_data_i,
    input  logic [xt_bus_pkg::bus_data_w-1:0] ems_read_data_i,
    input  logic                              dss_full_i,
    output logic [xt_bus_pkg::bus_data_w-1:0] data_bus_o,
    output logic                              data_bus_out_from_chipset_o
);
    import xt_bus_pkg::*;

    logic [bus_data_w-1:0] lpt_data_q;
    logic [bus_data_w-1:0] read_data;
    logic                  io_rd;
    read_src_e             read_src;
    read_src_e             src_q;

    always_ff @(posedge clock, posedge reset) begin
        if (reset)
            lpt_data_q <= '1;
        else if (lpt_data_sel_i & ~io_write_n_i)
            lpt_data_q <= data_i;
    end

    // A memory strobe together with an I/O read is a bus conflict
    assign io_rd = ~io_read_n_i & memory_read_n_i;

    // Interrupt acknowledge wins over everything
    always_comb begin
        if (~interrupt_acknowledge_n_i)
            read_src = src_inta;
        else if (io_rd & pic_sel_i)
            read_src = src_pic;
        else if (io_rd & pit_sel_i)
            read_src = src_pit;
        else if (io_rd & ppi_sel_i)
            read_src = src_ppi;
        else if (io_rd & ems_sel_i)
            read_src = src_ems;
        else if (io_rd & lpt_data_sel_i)
            read_src = src_lpt_data;
        else if (io_rd & lpt_ctl_sel_i)
            read_src = src_lpt_ctl;
        else
            read_src = src_none;
    end

    always_comb begin
        read_data = '0;
        case (read_src)
            src_inta, src_pic: read_data = pic_data_i;
            src_pit:           read_data = pit_data_i;
            src_ppi:           read_data = ppi_data_i;
            src_ems:           read_data = ems_read_data_i;
            src_lpt_data:      read_data = lpt_data_q;
            src_lpt_ctl:       read_data[lpt_dss_full_bit] = dss_full_i;
            default:           read_data = '0;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_o                  <= '0;
            data_bus_out_from_chipset_o <= 1'b0;
            src_q                       <= src_none;
        end else begin
            data_bus_o                  <= read_data;
            data_bus_out_from_chipset_o <= (read_src != src_none);
            src_q                       <= read_src;
        end
    end

    no_drive_when_idle: assert property (@(posedge clock) disable iff (reset)
        (src_q == src_none) |-> !data_bus_out_from_chipset_o)
        else $error("chipset drives the bus with no read source");

endmodule

/* xt_peripherals.sv */
// XT peripheral glue top level
// The 8259, 8253 and 8255 sit outside; this block decodes their selects,
// maps EMS pages, makes the timer clock and muxes read data
module xt_peripherals (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [xt_bus_pkg::bus_addr_w-1:0]   address_i,
    input  logic [xt_bus_pkg::bus_data_w-1:0]   data_i,
    input  logic                                address_enable_n_i,
    input  logic                                io_read_n_i,
    input  logic                                io_write_n_i,
    input  logic                                memory_read_n_i,
    input  logic                                interrupt_acknowledge_n_i,
    input  logic                                ems_enabled_i,
    input  logic [1:0]                          ems_window_i,
    input  logic                                peripheral_clock_i,
    input  logic [xt_bus_pkg::bus_data_w-1:0]   pic_data_i,
    input  logic [xt_bus_pkg::bus_data_w-1:0]   pit_data_i,
    input  logic [xt_bus_pkg::bus_data_w-1:0]   ppi_data_i,
    input  logic                                dss_full_i,
    output logic                                dma_cs_n_o,
    output logic                                pic_cs_n_o,
    output logic                                pit_cs_n_o,
    output logic                                ppi_cs_n_o,
    output logic                                dma_page_cs_n_o,
    output logic [xt_ems_pkg::ems_slots-1:0]    ems_bank_o,
    output logic [xt_ems_pkg::ems_slots-1:0][xt_ems_pkg::ems_map_w-1:0] ems_map_o,
    output logic                                timer_clock_o,
    output logic [xt_bus_pkg::bus_data_w-1:0]   data_bus_o,
    output logic                                data_bus_out_from_chipset_o
);
    import xt_bus_pkg::*;

    logic                  pic_sel;
    logic                  pit_sel;
    logic                  ppi_sel;
    logic                  ems_sel;
    logic                  lpt_data_sel;
    logic                  lpt_ctl_sel;
    logic                  io_cycle;
    logic [bus_data_w-1:0] ems_read_data;

    io_decoder u_io_decoder (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .dma_cs_n_o         (dma_cs_n_o),
        .pic_cs_n_o         (pic_cs_n_o),
        .pit_cs_n_o         (pit_cs_n_o),
        .ppi_cs_n_o         (ppi_cs_n_o),
        .dma_page_cs_n_o    (dma_page_cs_n_o),
        .pic_sel_o          (pic_sel),
        .pit_sel_o          (pit_sel),
        .ppi_sel_o          (ppi_sel),
        .ems_sel_o          (ems_sel),
        .lpt_data_sel_o     (lpt_data_sel),
        .lpt_ctl_sel_o      (lpt_ctl_sel),
        .io_cycle_o         (io_cycle)
    );

    ems_mapper u_ems_mapper (
        .clock           (clock),
        .reset           (reset),
        .address_i       (address_i),
        .data_i          (data_i),
        .io_write_n_i    (io_write_n_i),
        .ems_sel_i       (ems_sel),
        .io_cycle_i      (io_cycle),
        .ems_enabled_i   (ems_enabled_i),
        .ems_window_i    (ems_window_i),
        .ems_bank_o      (ems_bank_o),
        .ems_map_o       (ems_map_o),
        .ems_read_data_o (ems_read_data)
    );

    timer_clock_gen u_timer_clock_gen (
        .clock              (clock),
        .reset              (reset),
        .peripheral_clock_i (peripheral_clock_i),
        .timer_clock_o      (timer_clock_o)
    );

    bus_readback u_bus_readback (
        .clock                       (clock),
        .reset                       (reset),
        .io_read_n_i                 (io_read_n_i),
        .io_write_n_i                (io_write_n_i),
        .memory_read_n_i             (memory_read_n_i),
        .interrupt_acknowledge_n_i   (interrupt_acknowledge_n_i),
        .data_i                      (data_i),
        .pic_sel_i                   (pic_sel),
        .pit_sel_i                   (pit_sel),
        .ppi_sel_i                   (ppi_sel),
        .ems_sel_i                   (ems_sel),
        .lpt_data_sel_i              (lpt_data_sel),
        .lpt_ctl_sel_i               (lpt_ctl_sel),
        .pic_data_i                  (pic_data_i),
        .pit_data_i                  (pit_data_i),
        .ppi_data_i                  (ppi_data_i),
        .ems_read_data_i             (ems_read_data),
        .dss_full_i                  (dss_full_i),
        .data_bus_o                  (data_bus_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

/* tb_xt_peripherals.sv */
// Testbench for the XT peripheral glue
// Drives random I/O and memory cycles, keeps a reference model of the
// EMS slots and the parallel latch, and compares every cycle
module tb_xt_peripherals;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period    = 8;
    localparam int n_cs_tests    = 200;
    localparam int n_ems_tests   = 64;
    localparam int n_bank_tests  = 40;
    localparam int n_timer_edges = 10;
    localparam int num_tests     = n_cs_tests + n_ems_tests + 4 * n_bank_tests
                                   + n_timer_edges + 24;

    logic            clock;
    logic            reset;
    logic [19:0]     address;
    logic [7:0]      data;
    logic            address_enable_n;
    logic            io_read_n;
    logic            io_write_n;
    logic            memory_read_n;
    logic            interrupt_acknowledge_n;
    logic            ems_enabled;
    logic [1:0]      ems_window;
    logic            peripheral_clock;
    logic [7:0]      pic_data;
    logic [7:0]      pit_data;
    logic [7:0]      ppi_data;
    logic            dss_full;
    logic            dma_cs_n;
    logic            pic_cs_n;
    logic            pit_cs_n;
    logic            ppi_cs_n;
    logic            dma_page_cs_n;
    logic [3:0]      ems_bank;
    logic [3:0][6:0] ems_map;
    logic            timer_clock;
    logic [7:0]      data_bus;
    logic            data_bus_out_from_chipset;

    // Values applied at the next falling edge
    logic            next_enabled;
    logic [1:0]      next_window;
    logic            next_pclk;

    // Reference state, one byte per slot as {enable, page}
    logic [31:0]     seed;
    logic [7:0]      ems_state [4];
    logic [7:0]      lpt_latch;
    logic            pending_write;
    logic [1:0]      pending_slot;
    logic [7:0]      pending_state;

    logic            checking;
    logic            chk_timer;
    int              exp_toggles;
    logic [4:0]      exp_cs;
    logic [3:0]      exp_bank;
    logic [6:0]      exp_map [4];
    logic [8:0]      exp_rd;

    xt_peripherals u_xt_peripherals (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data),
        .address_enable_n_i          (address_enable_n),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .memory_read_n_i             (memory_read_n),
        .interrupt_acknowledge_n_i   (interrupt_acknowledge_n),
        .ems_enabled_i               (ems_enabled),
        .ems_window_i                (ems_window),
        .peripheral_clock_i          (peripheral_clock),
        .pic_data_i                  (pic_data),
        .pit_data_i                  (pit_data),
        .ppi_data_i                  (ppi_data),
        .dss_full_i                  (dss_full),
        .dma_cs_n_o                  (dma_cs_n),
        .pic_cs_n_o                  (pic_cs_n),
        .pit_cs_n_o                  (pit_cs_n),
        .ppi_cs_n_o                  (ppi_cs_n),
        .dma_page_cs_n_o             (dma_page_cs_n),
        .ems_bank_o                  (ems_bank),
        .ems_map_o                   (ems_map),
        .timer_clock_o               (timer_clock),
        .data_bus_o                  (data_bus),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    function automatic logic [23:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[31:8];
    endfunction

    function automatic logic is_io(logic aen_n, logic ior_n, logic iow_n);
        return !aen_n && (!ior_n || !iow_n);
    endfunction

    // Bit n is the chip in 32-byte block n of 000h-0FFh
    function automatic logic [4:0] expected_selects(logic [19:0] addr, logic io);
        logic [4:0] cs;
        for (int b = 0; b < 5; b++)
            cs[b] = io && (addr[9:8] == 2'b00) && (addr[7:5] == 3'(b));
        return cs;
    endfunction

    function automatic logic [7:0] ems_slot_next(logic [7:0] state, logic [7:0] value);
        if (value == 8'hFF)
            return 8'h7F;
        else if (value < 8'h80)
            return {1'b1, value[6:0]};
        else
            return state;
    endfunction

    function automatic logic [3:0] bank_decode(logic [19:0] addr, logic [1:0] window,
                                               logic io);
        logic [3:0] base;
        logic [3:0] banks;
        case (window)
            2'd0:    base = 4'hA;
            2'd1:    base = 4'hC;
            default: base = 4'hD;
        endcase
        for (int k = 0; k < 4; k++)
            banks[k] = !io && ems_state[k][7] && (addr[19:14] == {base, 2'(k)});
        return banks;
    endfunction

    // Returns {flag, data} as registered one edge later
    function automatic logic [8:0] readback_model(logic [19:0] addr, logic io,
                                                  logic ior_n, logic inta_n);
        logic [4:0] cs;
        logic [7:0] ems_val;
        logic       rd;
        cs      = expected_selects(addr, io);
        ems_val = ems_state[addr[1:0]][7] ? {1'b0, ems_state[addr[1:0]][6:0]} : 8'hFF;
        rd      = io && !ior_n;
        if (!inta_n)
            return {1'b1, pic_data};
        else if (rd && cs[1])
            return {1'b1, pic_data};
        else if (rd && cs[2])
            return {1'b1, pit_data};
        else if (rd && cs[3])
            return {1'b1, ppi_data};
        else if (rd && addr[15:0] >= 16'h0260 && addr[15:0] <= 16'h0263)
            return {1'b1, ems_val};
        else if (rd && addr[15:0] == 16'h0378)
            return {1'b1, lpt_latch};
        else if (rd && addr[15:0] == 16'h0379)
            return {1'b1, 1'b0, dss_full, 6'h00};
        else
            return 9'h000;
    endfunction

    function automatic logic timer_level(int toggles);
        return toggles[0];
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        stop_with_failure($sformatf("[FAIL] %0t ns: %s", $time, msg));
    endtask

    task automatic drive_cycle(input logic [19:0] addr, input logic [7:0] wdata,
                               input logic aen_n, input logic ior_n,
                               input logic iow_n, input logic inta_n);
        logic        io;
        logic [1:0]  slot;
        logic [23:0] r;
        @(negedge clock);
        r                       = next_rand();
        address                 = addr;
        data                    = wdata;
        address_enable_n        = aen_n;
        io_read_n               = ior_n;
        io_write_n              = iow_n;
        memory_read_n           = ~(ior_n & iow_n);
        interrupt_acknowledge_n = inta_n;
        ems_enabled             = next_enabled;
        ems_window              = next_window;
        peripheral_clock        = next_pclk;
        pic_data                = r[7:0];
        pit_data                = r[15:8];
        ppi_data                = r[23:16];
        r                       = next_rand();
        dss_full                = r[5];
        io                      = is_io(aen_n, ior_n, iow_n);
        slot                    = addr[1:0];
        // Read data sees the slots before last cycle's write lands
        exp_rd = readback_model(addr, io, ior_n, inta_n);
        if (pending_write)
            ems_state[pending_slot] = ems_slot_next(ems_state[pending_slot], pending_state);
        pending_write = io && !iow_n && ems_enabled
                        && addr[15:0] >= 16'h0260 && addr[15:0] <= 16'h0263;
        pending_slot  = slot;
        pending_state = wdata;
        if (io && !iow_n && addr[15:0] == 16'h0378)
            lpt_latch = wdata;
        exp_cs   = expected_selects(addr, io);
        exp_bank = bank_decode(addr, ems_window, io);
        for (int k = 0; k < 4; k++)
            exp_map[k] = ems_state[k][6:0];
    endtask

    task automatic idle_cycle();
        drive_cycle(20'h00000, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic io_write(input logic [19:0] addr, input logic [7:0] value);
        drive_cycle(addr, value, 1'b0, 1'b1, 1'b0, 1'b1);
    endtask

    task automatic io_read(input logic [19:0] addr);
        drive_cycle(addr, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1);
    endtask

    // Samples between the rising and the falling edge
    initial begin : compare_outputs
        logic       prev_timer;
        logic [4:0] cs_act;
        int         toggles;
        prev_timer = 1'b0;
        toggles    = 0;
        forever begin
            @(posedge clock);
            #2;
            if (checking) begin
                cs_act = ~{dma_page_cs_n, ppi_cs_n, pit_cs_n, pic_cs_n, dma_cs_n};
                if (timer_clock !== prev_timer)
                    toggles++;
                prev_timer = timer_clock;
                assert ($onehot0(cs_act))
                    else value_error($sformatf("several chip selects low: %b", cs_act));
                assert (cs_act === exp_cs)
                    else value_error($sformatf("chip selects %b, expected %b", cs_act, exp_cs));
                assert (ems_bank === exp_bank)
                    else value_error($sformatf("banks %b, expected %b", ems_bank, exp_bank));
                for (int k = 0; k < 4; k++) begin
                    assert (ems_map[k] === exp_map[k])
                        else value_error($sformatf("slot %0d page %h, expected %h",
                                                   k, ems_map[k], exp_map[k]));
                end
                assert ({data_bus_out_from_chipset, data_bus} === exp_rd)
                    else value_error($sformatf("read flag %b data %h, expected %b %h",
                                               data_bus_out_from_chipset, data_bus,
                                               exp_rd[8], exp_rd[7:0]));
                if (chk_timer) begin
                    assert (toggles == exp_toggles && timer_clock === timer_level(exp_toggles))
                        else value_error($sformatf("timer toggled %0d times, expected %0d",
                                                   toggles, exp_toggles));
                end
            end
        end
    end

    initial begin : watchdog
        #(num_tests * 20 * clk_period);
        stop_with_failure("Timeout: the tests did not finish in the expected time");
    end

    initial begin : stimulus
        logic [23:0] a;
        logic [23:0] b;
        logic [19:0] addr;
        logic [7:0]  value;
        seed          = 32'h0af4b6c4;
        checking      = 1'b0;
        chk_timer     = 1'b0;
        exp_toggles   = 0;
        pending_write = 1'b0;
        pending_slot  = 2'd0;
        pending_state = 8'h00;
        lpt_latch     = 8'hFF;
        for (int k = 0; k < 4; k++)
            ems_state[k] = 8'h00;
        reset                   = 1'b1;
        address                 = 20'h00000;
        data                    = 8'h00;
        address_enable_n        = 1'b1;
        io_read_n               = 1'b1;
        io_write_n              = 1'b1;
        memory_read_n           = 1'b1;
        interrupt_acknowledge_n = 1'b1;
        ems_enabled             = 1'b0;
        ems_window              = 2'd0;
        peripheral_clock        = 1'b0;
        pic_data                = 8'h00;
        pit_data                = 8'h00;
        ppi_data                = 8'h00;
        dss_full                = 1'b0;
        next_enabled            = 1'b0;
        next_window             = 2'd0;
        next_pclk               = 1'b0;
        repeat (4) @(negedge clock);
        reset = 1'b0;

        // Reset state, timer starts low
        idle_cycle();
        checking  = 1'b1;
        chk_timer = 1'b1;
        idle_cycle();
        chk_timer = 1'b0;

        // Chip select decode with random strobes
        for (int i = 0; i < n_cs_tests; i++) begin
            a    = next_rand();
            b    = next_rand();
            addr = a[19:0];
            if (a[20])
                addr[9:8] = 2'b00;
            drive_cycle(addr, b[7:0], b[11:10] == 2'b00, b[8], b[9], 1'b1);
        end

        // EMS write rule, readback after the write has landed
        next_enabled = 1'b1;
        for (int i = 0; i < n_ems_tests; i++) begin
            a = next_rand();
            b = next_rand();
            case (b[1:0])
                2'd0:    value = 8'hFF;
                2'd3:    value = {1'b1, b[8:2]};
                default: value = {1'b0, b[8:2]};
            endcase
            next_enabled = (b[12:10] != 3'd0);
            addr = {a[19:16], 14'h0098, a[1:0]};
            io_write(addr, value);
            idle_cycle();
            io_read(addr);
        end
        next_enabled = 1'b1;

        // Known slots for the bank test, slot 1 disabled
        io_write(20'h00260, 8'h05);
        io_write(20'h00261, 8'hFF);
        io_write(20'h00262, 8'h7F);
        io_write(20'h00263, 8'h40);
        idle_cycle();
        for (int w = 0; w < 4; w++) begin
            next_window = 2'(w);
            for (int i = 0; i < n_bank_tests; i++) begin
                a    = next_rand();
                b    = next_rand();
                addr = a[19:0];
                if (a[20])
                    addr[19:16] = 4'hA + {2'b00, b[3:2]};
                drive_cycle(addr, b[7:0], 1'b0, b[12:10] != 3'd0, 1'b1, 1'b1);
            end
        end

        // Parallel port latch and status
        a = next_rand();
        io_write(20'h00378, a[7:0]);
        io_read(20'h00378);
        io_write(20'h00379, ~a[7:0]);
        io_read(20'h00378);
        repeat (4) io_read(20'h00379);
        io_read(20'h003F8);
        io_read(20'h00300);
        idle_cycle();

        // Interrupt acknowledge over every read source
        drive_cycle(20'h00020, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0);
        drive_cycle(20'h00040, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0);
        drive_cycle(20'h00060, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0);
        drive_cycle(20'h00261, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0);
        drive_cycle(20'h00378, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0);
        drive_cycle(20'h00379, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0);
        drive_cycle(20'h00000, 8'h00, 1'b1, 1'b1, 1'b1, 1'b0);
        idle_cycle();

        // Slow peripheral clock with random phases
        for (int e = 0; e < n_timer_edges; e++) begin
            b         = next_rand();
            next_pclk = 1'b1;
            repeat (2 + int'(b[2:0])) idle_cycle();
            next_pclk = 1'b0;
            repeat (2 + int'(b[5:3])) idle_cycle();
        end
        repeat (4) idle_cycle();
        exp_toggles = n_timer_edges;
        chk_timer   = 1'b1;
        idle_cycle();
        @(negedge clock);

        $display("All checks passed");
        $finish;
    end

endmodule

/* all.f */
xt_bus_pkg.sv
xt_ems_pkg.sv
io_decoder.sv
ems_mapper.sv
timer_clock_gen.sv
bus_readback.sv
xt_peripherals.sv
tb_xt_peripherals.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_xt_peripherals
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
